/* design/boot_pkg.sv */
package boot_pkg;

	// Bus widths
	localparam int WORD_W = 16;
	localparam int ADDR_W = 16;
	localparam int FLASH_ADDR_W = 22;

	// Wide enough for a wait count of 1 to 15
	localparam int TIMER_W = 4;

	// One data word, flash side and RAM side alike
	typedef logic [WORD_W-1:0] word_t;

	// RAM word address, also used as the copy index
	typedef logic [ADDR_W-1:0] addr_t;

	// Flash word address
	typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

	// Instruction RAM write, address in the upper half
	typedef struct packed {
		addr_t addr;
		word_t data;
	} ram_write_t;

	// Copy sequencer states
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2,
		DONE  = 2'd3
	} boot_state_t;

endpackage

/* design/boot_fsm.sv */
`timescale 1ns/10ps

module boot_fsm #(
	parameter int BOOT_WORDS = 24,
	parameter int FLASH_WAIT = 3
) (
	input  logic                         raw_clk,
	input  logic                         rst_n,
	input  logic                         wait_done,
	output logic                         read_start,
	output logic [boot_pkg::TIMER_W-1:0] load_value,
	output logic                         reading,
	output logic                         write_strobe,
	output boot_pkg::addr_t              index,
	output logic                         boot_done
);

	localparam boot_pkg::addr_t LAST_INDEX = boot_pkg::addr_t'(BOOT_WORDS - 1);
	localparam logic [boot_pkg::TIMER_W-1:0] WAIT_LOAD = FLASH_WAIT[boot_pkg::TIMER_W-1:0];

	boot_pkg::boot_state_t state;
	boot_pkg::boot_state_t state_next;
	logic last_word;

	assign last_word = (index == LAST_INDEX);

	always_comb begin
		state_next = state;
		case (state)
			boot_pkg::IDLE: begin
				state_next = boot_pkg::READ;
			end
			boot_pkg::READ: begin
				// Timer flags the final wait cycle
				if (wait_done) begin
					state_next = boot_pkg::WRITE;
				end
			end
			boot_pkg::WRITE: begin
				if (last_word) begin
					state_next = boot_pkg::DONE;
				end else begin
					state_next = boot_pkg::READ;
				end
			end
			boot_pkg::DONE: begin
				state_next = boot_pkg::DONE;
			end
			default: begin
				state_next = boot_pkg::IDLE;
			end
		endcase
	end

	// High whenever the next cycle is a READ cycle, so the
	// registered flash enables line up with the READ state
	assign reading = (state_next == boot_pkg::READ);

	// First cycle of a new read, loads the wait timer
	assign read_start = reading && (state != boot_pkg::READ);
	assign load_value = WAIT_LOAD;

	assign write_strobe = (state == boot_pkg::WRITE);
	assign boot_done = (state == boot_pkg::DONE);

	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			state <= boot_pkg::IDLE;
			index <= '0;
		end else begin
			state <= state_next;
			// Index holds at the last word once copying ends
			if (write_strobe && !last_word) begin
				index <= index + 1'b1;
			end
		end
	end

endmodule

/* design/flash_wait_timer.sv */
`timescale 1ns/10ps

module flash_wait_timer (
	input  logic                         raw_clk,
	input  logic                         rst_n,
	input  logic                         load,
	input  logic [boot_pkg::TIMER_W-1:0] load_value,
	output logic                         wait_done
);

	logic [boot_pkg::TIMER_W-1:0] count;

	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;
		end else if (count != '0) begin
			count <= count - 1'b1;
		end
	end

	// Count reads 1 in the last wait cycle, then parks at zero
	assign wait_done = (count == 1);

endmodule

/* design/flash_read_port.sv */
`timescale 1ns/10ps

module flash_read_port (
	input  logic                  raw_clk,
	input  logic                  rst_n,
	input  logic                  reading,
	input  logic                  wait_done,
	input  boot_pkg::addr_t       index,
	input  boot_pkg::word_t       flash_data,
	output boot_pkg::flash_addr_t flash_addr,
	output logic                  flash_ce_n,
	output logic                  flash_oe_n,
	output boot_pkg::word_t       word
);

	logic read_active;

	// Chip and output enable move together for a plain read
	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			read_active <= 1'b0;
		end else begin
			read_active <= reading;
		end
	end

	assign flash_ce_n = ~read_active;
	assign flash_oe_n = ~read_active;

	// Step to the following word once the current one is sampled,
	// the address is stable again before the next read starts
	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			flash_addr <= '0;
		end else if (wait_done) begin
			flash_addr <= boot_pkg::flash_addr_t'(index) + 1'b1;
		end
	end

	// Data is valid at the end of the wait
	always_ff @(posedge raw_clk) begin
		if (wait_done) begin
			word <= flash_data;
		end
	end

endmodule

/* design/ram_write_port.sv */
`timescale 1ns/10ps

module ram_write_port (
	input  logic                 raw_clk,
	input  logic                 rst_n,
	input  logic                 write_strobe,
	input  boot_pkg::addr_t      index,
	input  boot_pkg::word_t      word,
	output boot_pkg::ram_write_t ram_wr,
	output logic                 ram_we,
	output boot_pkg::addr_t      written
);

	// Address and data for the RAM strobe port
	always_ff @(posedge raw_clk) begin
		if (write_strobe) begin
			ram_wr.addr <= index;
			ram_wr.data <= word;
		end
	end

	// One cycle write pulse, following the strobe
	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			ram_we <= 1'b0;
		end else begin
			ram_we <= write_strobe;
		end
	end

	// Words handed to the RAM so far
	always_ff @(posedge raw_clk) begin
		if (!rst_n) begin
			written <= '0;
		end else if (ram_we) begin
			written <= written + 1'b1;
		end
	end

endmodule

/* design/seg_decoder.sv */
`timescale 1ns/10ps

module seg_decoder (
	input  logic [3:0] digit,
	output logic [6:0] seg
);

	// Bit 0 is segment a through bit 6 for segment g
	always_comb begin
		case (digit)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			// Letters, b and d in lower case
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			4'hf: seg = 7'h71;
			default: seg = 7'h00;
		endcase
	end

endmodule

/* design/boot_top.sv */
`timescale 1ns/10ps

module boot_top #(
	parameter int BOOT_WORDS = 24,
	parameter int FLASH_WAIT = 3
) (
	input  logic                  raw_clk,
	input  logic                  rst_n,
	output boot_pkg::flash_addr_t flash_addr,
	input  boot_pkg::word_t       flash_data,
	output logic                  flash_ce_n,
	output logic                  flash_oe_n,
	output boot_pkg::ram_write_t  ram_wr,
	output logic                  ram_we,
	output logic                  boot_done,
	output logic [6:0]            seg_hi,
	output logic [6:0]            seg_lo
);

	// Sequencer
	logic wait_done;
	logic read_start;
	logic [boot_pkg::TIMER_W-1:0] load_value;
	logic reading;
	logic write_strobe;
	boot_pkg::addr_t index;

	boot_fsm #(
		.BOOT_WORDS(BOOT_WORDS),
		.FLASH_WAIT(FLASH_WAIT)
	) __boot_fsm (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.wait_done(wait_done),
		.read_start(read_start),
		.load_value(load_value),
		.reading(reading),
		.write_strobe(write_strobe),
		.index(index),
		.boot_done(boot_done)
	);

	flash_wait_timer __flash_wait_timer (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.load(read_start),
		.load_value(load_value),
		.wait_done(wait_done)
	);

	// Flash
	boot_pkg::word_t flash_word;

	flash_read_port __flash_read_port (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.reading(reading),
		.wait_done(wait_done),
		.index(index),
		.flash_data(flash_data),
		.flash_addr(flash_addr),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.word(flash_word)
	);

	// Instruction RAM
	boot_pkg::addr_t written;

	ram_write_port __ram_write_port (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.write_strobe(write_strobe),
		.index(index),
		.word(flash_word),
		.ram_wr(ram_wr),
		.ram_we(ram_we),
		.written(written)
	);

	// Progress display, low byte of the word count
	seg_decoder __seg_hi (
		.digit(written[7:4]),
		.seg(seg_hi)
	);

	seg_decoder __seg_lo (
		.digit(written[3:0]),
		.seg(seg_lo)
	);

endmodule

/* tests/boot_properties.sv */
`timescale 1ns/10ps

module boot_properties (
	input logic raw_clk,
	input logic rst_n,
	input logic ram_we,
	input logic flash_ce_n,
	input logic flash_oe_n,
	input logic boot_done
);

	// Number of failed checks so far
	int unsigned failures = 0;

	we_single: assert property (@(posedge raw_clk) disable iff (!rst_n) ram_we |=> !ram_we)
		else begin
			$error("ram_we stayed high for two cycles");
			failures++;
		end

	// Plain reads only, and none once booted
	oe_with_ce: assert property (@(posedge raw_clk)
			!flash_ce_n |-> !flash_oe_n && !boot_done)
		else begin
			$error("flash enabled with flash_oe_n high or after boot_done");
			failures++;
		end

	done_holds: assert property (@(posedge raw_clk) $fell(boot_done) |-> !$past(rst_n))
		else begin
			$error("boot_done fell without a reset");
			failures++;
		end

endmodule

bind boot_top boot_properties props (
	.raw_clk(raw_clk),
	.rst_n(rst_n),
	.ram_we(ram_we),
	.flash_ce_n(flash_ce_n),
	.flash_oe_n(flash_oe_n),
	.boot_done(boot_done)
);

/* tests/boot_tb.sv */
`timescale 1ns/10ps

module boot_tb;

	localparam int BOOT_WORDS = 24;
	localparam int FLASH_WAIT = 3;

	// Segment bit 0 is a, bit 6 is g
	localparam logic [6:0] GLYPHS [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d,
		7'h7d, 7'h07, 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};

	logic raw_clk;
	logic rst_n;
	boot_pkg::flash_addr_t flash_addr;
	boot_pkg::word_t flash_data;
	logic flash_ce_n;
	logic flash_oe_n;
	boot_pkg::ram_write_t ram_wr;
	logic ram_we;
	logic boot_done;
	logic [6:0] seg_hi;
	logic [6:0] seg_lo;

	integer seed = 32'hcec11650;
	boot_pkg::word_t image [BOOT_WORDS];
	int cycle_count = 0;

	boot_top #(
		.BOOT_WORDS(BOOT_WORDS),
		.FLASH_WAIT(FLASH_WAIT)
	) DUT (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce_n(flash_ce_n),
		.flash_oe_n(flash_oe_n),
		.ram_wr(ram_wr),
		.ram_we(ram_we),
		.boot_done(boot_done),
		.seg_hi(seg_hi),
		.seg_lo(seg_lo)
	);

	initial begin
		raw_clk = 1'b0;
		forever #50 raw_clk = ~raw_clk;
	end

	always @(posedge raw_clk) begin
		cycle_count <= cycle_count + 1;
	end

	// Flash answers one cycle after address and enables settle, junk otherwise
	always @(posedge raw_clk) begin
		if (flash_oe_n == 1'b0) begin
			flash_data <= image[int'(flash_addr)];
		end else begin
			flash_data <= boot_pkg::word_t'($random(seed));
		end
	end

	task automatic stop_run();
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input boot_pkg::word_t exp,
			input boot_pkg::word_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input boot_pkg::addr_t exp,
			input boot_pkg::addr_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_flash_addr(input string name, input boot_pkg::flash_addr_t exp,
			input boot_pkg::flash_addr_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_seg(input string name, input logic [6:0] exp, input logic [6:0] act);
		if (act !== exp) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %b actual %b", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s expected %0d actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic apply_reset();
		@(posedge raw_clk);
		rst_n <= 1'b0;
		for (int i = 0; i < 16; i++) begin
			@(negedge raw_clk);
			if (i > 0) begin
				check_bit("reset ram_we", 1'b0, ram_we);
				check_bit("reset boot_done", 1'b0, boot_done);
				check_bit("reset flash_ce_n", 1'b1, flash_ce_n);
				check_bit("reset flash_oe_n", 1'b1, flash_oe_n);
				check_seg("reset seg_hi", GLYPHS[0], seg_hi);
				check_seg("reset seg_lo", GLYPHS[0], seg_lo);
			end
		end
		// New image for every copy
		foreach (image[i]) begin
			image[i] = boot_pkg::word_t'($random(seed));
		end
		@(posedge raw_clk);
		rst_n <= 1'b1;
	endtask

	task automatic wait_write(input int k);
		int waited;
		waited = 0;
		@(negedge raw_clk);
		while (ram_we !== 1'b1) begin
			check_bit($sformatf("boot_done before %0d", k), 1'b0, boot_done);
			// Word k is read from flash word k
			if (flash_oe_n === 1'b0) begin
				check_flash_addr($sformatf("flash_addr %0d", k),
					boot_pkg::flash_addr_t'(k), flash_addr);
			end
			waited++;
			if (waited > 4 * FLASH_WAIT + 8) begin
				$display("Timeout: the RAM write of word %0d never came", k);
				stop_run();
			end else begin
				@(negedge raw_clk);
			end
		end
	endtask

	task automatic check_copy();
		int last;
		int count;
		last = 0;
		for (int k = 0; k < BOOT_WORDS; k++) begin
			wait_write(k);
			if (k > 0) begin
				check_count($sformatf("spacing %0d", k), FLASH_WAIT + 1, cycle_count - last);
			end
			last = cycle_count;
			check_addr($sformatf("address %0d", k), boot_pkg::addr_t'(k), ram_wr.addr);
			check_word($sformatf("data %0d", k), image[k], ram_wr.data);
			check_bit($sformatf("boot_done at %0d", k), k == BOOT_WORDS - 1, boot_done);
			@(negedge raw_clk);
			count = k + 1;
			check_seg($sformatf("seg_hi after %0d", k), GLYPHS[(count / 16) % 16], seg_hi);
			check_seg($sformatf("seg_lo after %0d", k), GLYPHS[count % 16], seg_lo);
		end
		// Quiet after the last word
		repeat (50) begin
			@(negedge raw_clk);
			check_bit("tail flash_ce_n", 1'b1, flash_ce_n);
			check_bit("tail flash_oe_n", 1'b1, flash_oe_n);
			check_bit("tail ram_we", 1'b0, ram_we);
			check_bit("tail boot_done", 1'b1, boot_done);
		end
		check_seg("final seg_hi", GLYPHS[1], seg_hi);
		check_seg("final seg_lo", GLYPHS[8], seg_lo);
	endtask

	initial begin
		int cycles;
		rst_n = 1'b0;
		flash_data = '0;
		apply_reset();
		check_copy();
		// Reset hits at a random point of the copy
		for (int run = 0; run < 2; run++) begin
			apply_reset();
			cycles = 6 + ({$random(seed)} % 80);
			repeat (cycles) @(posedge raw_clk);
			apply_reset();
			check_copy();
		end
		if (DUT.props.failures != 0) begin
			$display("%0d bound property checks failed", DUT.props.failures);
			stop_run();
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

/* list.f */
design/boot_pkg.sv
design/boot_fsm.sv
design/flash_wait_timer.sv
design/flash_read_port.sv
design/ram_write_port.sv
design/seg_decoder.sv
design/boot_top.sv
tests/boot_properties.sv
tests/boot_tb.sv

/* Makefile */
TOOL       = verilator
TOP        = boot_tb
FILELIST   = list.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
BUILD_DIR  = obj_dir
LOG        = sim.log
FAIL_MSG   = sim failed
PASS_MSG   = sim passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Result: FAIL, run ended early"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
